// File: common/led_drv_pkg.sv
// LED driver chain shared definitions

package led_drv_pkg;

   // Chain geometry
   // One data line per driver chip
   localparam int n_drivers = 30;
   // Function control word length
   localparam int conf_bits = 48;
   // Grayscale bits per segment, RGB of one scan slot
   localparam int gs_bits = 48;
   // Eight WRTGS segments plus the closing LATGS one
   localparam int n_segments = 9;

   // Field widths of the bit command
   // Enough to index all 48 configuration bits
   localparam int conf_idx_w = 6;
   // Sout mux select over 30 drivers
   localparam int mux_w = 5;

   // Command latch widths, counted in shift-clock rises with LAT high
   // Enable function control write
   localparam int fcwrten_bits = 15;
   // Write function control latch
   localparam int wrtfc_bits = 5;
   // Write grayscale latch
   localparam int wrtgs_bits = 1;
   // Grayscale latch, then copy to the display bank
   localparam int latgs_bits = 3;

   // One pixel word, one bit per data line
   typedef logic [n_drivers-1:0] pixel_t;

   // Sequencer phases in boot order
   // Stream loops forever once reached
   typedef enum logic [2:0] {
      phase_stall,
      phase_prepare_config,
      phase_config,
      phase_lod,
      phase_stream
   } drv_phase_t;

   // Payload of one shift-clock bit
   typedef enum logic [1:0] {
      kind_idle,
      kind_conf,
      kind_lod,
      kind_pixel
   } bit_kind_t;

   // Sequencer to shifter bit command
   typedef struct packed {
      bit_kind_t              kind;
      // Latch level held through this bit
      logic                   lat;
      // Bit of serialized_conf, counted from the MSB
      logic [conf_idx_w-1:0]  conf_index;
      // Driver whose sout is routed back
      logic [mux_w-1:0]       mux_sel;
      // Bit period with sclk held low
      logic                   blank;
      logic                   gclk_en;
   } bit_cmd_t;

endpackage

// File: hw/slice_buffer.sv
// Credit-returning pixel FIFO

module slice_buffer #(
   parameter int slice_depth = 8
) (
   input  logic                clk_lse_quad,
   input  logic                framebuffer_sync,
   // Framebuffer side pushes one word per credit
   input  logic                push,
   input  led_drv_pkg::pixel_t push_data,
   // Shifter side
   input  logic                pop,
   output logic                word_valid,
   output led_drv_pkg::pixel_t word,
   // One credit back per word drained
   output logic                credit
);

   import led_drv_pkg::*;

   localparam int ptr_w = (slice_depth > 1) ? $clog2(slice_depth) : 1;
   localparam int cnt_w = $clog2(slice_depth + 1);

   // Pixel word storage
   pixel_t mem [slice_depth];

   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;

   // Head word is read straight from storage
   assign word       = mem[rd_ptr];
   assign word_valid = (count != '0);

   // Write side
   always_ff @(posedge clk_lse_quad) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // Pointers wrap at the depth, which need not be a power of two
   always_ff @(posedge clk_lse_quad or posedge framebuffer_sync) begin
      if (framebuffer_sync) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == ptr_w'(slice_depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(slice_depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Push and pop may land together on the occupancy
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // Credit goes back the cycle after the word leaves
         credit <= pop;
      end
   end

endmodule

// File: hw/driver/driver_sequencer.sv
// Boot and frame schedule sequencer

module driver_sequencer #(
   parameter int blank_bits = 80
) (
   input  logic                  clk_lse_quad,
   input  logic                  framebuffer_sync,
   // Shifter has taken the current command
   input  logic                  bit_done,
   output led_drv_pkg::bit_cmd_t cmd,
   output logic                  cmd_valid
);

   import led_drv_pkg::*;

   // Counter must reach both the blanking length and the longest boot phase
   localparam int span  = (blank_bits > conf_bits) ? blank_bits : conf_bits;
   localparam int cnt_w = $clog2(span + 1);

   drv_phase_t       phase;
   // Bit index within the phase, or within blanking or a segment in stream
   logic [cnt_w-1:0] bit_cnt;
   // Frame position
   logic [3:0]       seg_cnt;
   logic             in_blank;

   // Last-bit detection per phase
   logic last_prep;
   logic last_conf;
   logic last_lod;
   logic last_blank;
   logic last_seg_bit;
   logic last_seg;

   assign last_prep    = (bit_cnt == cnt_w'(fcwrten_bits - 1));
   assign last_conf    = (bit_cnt == cnt_w'(conf_bits - 1));
   assign last_lod     = (bit_cnt == cnt_w'(n_drivers - 1));
   assign last_blank   = (bit_cnt == cnt_w'(blank_bits - 1));
   assign last_seg_bit = (bit_cnt == cnt_w'(gs_bits - 1));
   assign last_seg     = (seg_cnt == 4'(n_segments - 1));

   // Schedule advances one bit per bit_done
   always_ff @(posedge clk_lse_quad or posedge framebuffer_sync) begin
      if (framebuffer_sync) begin
         phase     <= phase_stall;
         bit_cnt   <= '0;
         seg_cnt   <= '0;
         in_blank  <= 1'b0;
         cmd_valid <= 1'b0;
      end else begin
         // First command is ready one cycle out of reset
         cmd_valid <= 1'b1;
         if (bit_done) begin
            case (phase)
               phase_stall: begin
                  phase   <= phase_prepare_config;
                  bit_cnt <= '0;
               end
               phase_prepare_config: begin
                  bit_cnt <= last_prep ? '0 : bit_cnt + 1'b1;
                  if (last_prep) begin
                     phase <= phase_config;
                  end
               end
               phase_config: begin
                  bit_cnt <= last_conf ? '0 : bit_cnt + 1'b1;
                  if (last_conf) begin
                     phase <= phase_lod;
                  end
               end
               phase_lod: begin
                  bit_cnt <= last_lod ? '0 : bit_cnt + 1'b1;
                  if (last_lod) begin
                     // Every frame opens with blanking
                     phase    <= phase_stream;
                     in_blank <= 1'b1;
                     seg_cnt  <= '0;
                  end
               end
               phase_stream: begin
                  if (in_blank) begin
                     bit_cnt <= last_blank ? '0 : bit_cnt + 1'b1;
                     if (last_blank) begin
                        in_blank <= 1'b0;
                     end
                  end else begin
                     bit_cnt <= last_seg_bit ? '0 : bit_cnt + 1'b1;
                     if (last_seg_bit) begin
                        // After the LATGS segment the next frame starts
                        seg_cnt  <= last_seg ? '0 : seg_cnt + 1'b1;
                        in_blank <= last_seg;
                     end
                  end
               end
               default: begin
                  phase   <= phase_stall;
                  bit_cnt <= '0;
               end
            endcase
         end
      end
   end

   // Decode of the current bit
   always_comb begin
      cmd = '0;
      case (phase)
         phase_stall: begin
            // Single quiet bit, no rise
            cmd.blank = 1'b1;
         end
         phase_prepare_config: begin
            // FCWRTEN, all rises under LAT
            cmd.lat = 1'b1;
         end
         phase_config: begin
            cmd.kind       = kind_conf;
            cmd.conf_index = conf_idx_w'(bit_cnt);
            // WRTFC on the tail of the word
            cmd.lat        = (bit_cnt >= cnt_w'(conf_bits - wrtfc_bits));
         end
         phase_lod: begin
            cmd.kind    = kind_lod;
            cmd.mux_sel = mux_w'(bit_cnt);
         end
         phase_stream: begin
            cmd.gclk_en = 1'b1;
            if (in_blank) begin
               cmd.blank = 1'b1;
            end else begin
               cmd.kind = kind_pixel;
               // LATGS closes the frame, WRTGS closes the other segments
               if (last_seg) begin
                  cmd.lat = (bit_cnt >= cnt_w'(gs_bits - latgs_bits));
               end else begin
                  cmd.lat = (bit_cnt >= cnt_w'(gs_bits - wrtgs_bits));
               end
            end
         end
         default: begin
            cmd.blank = 1'b1;
         end
      endcase
   end

endmodule

// File: hw/driver/driver_shifter.sv
// Two-cycle driver bit engine

module driver_shifter (
   input  logic                           clk_lse_quad,
   input  logic                           framebuffer_sync,
   // Sequencer side
   input  led_drv_pkg::bit_cmd_t          cmd,
   input  logic                           cmd_valid,
   output logic                           bit_done,
   // Slice buffer side
   input  logic                           word_valid,
   input  led_drv_pkg::pixel_t            word,
   output logic                           pop,
   input  logic [led_drv_pkg::conf_bits-1:0] serialized_conf,
   // Open detection strobe
   output logic                           sample,
   output logic [led_drv_pkg::mux_w-1:0]  sample_sel,
   // Driver pins
   output logic                           driver_sclk,
   output logic                           driver_gclk,
   output logic                           driver_lat,
   output led_drv_pkg::pixel_t            drivers_sin,
   output logic [led_drv_pkg::mux_w-1:0]  driver_sout_mux
);

   import led_drv_pkg::*;

   // Low half when clear, high half when set
   logic step;
   // Attributes of the bit on the pins
   logic blank_q;
   logic lod_q;
   logic gclk_en_q;
   logic load;
   logic conf_bit;

   // Pixel bits stall with sclk low until a word is there
   assign load = ~step & cmd_valid & ((cmd.kind != kind_pixel) | word_valid);
   // Word leaves on the same edge it reaches the pins
   assign pop  = load & (cmd.kind == kind_pixel);
   // MSB of the configuration goes out first
   assign conf_bit = serialized_conf[(conf_bits - 1) - int'(cmd.conf_index)];

   always_ff @(posedge clk_lse_quad or posedge framebuffer_sync) begin
      if (framebuffer_sync) begin
         step            <= 1'b0;
         blank_q         <= 1'b0;
         lod_q           <= 1'b0;
         gclk_en_q       <= 1'b0;
         bit_done        <= 1'b0;
         sample          <= 1'b0;
         sample_sel      <= '0;
         driver_sclk     <= 1'b0;
         driver_gclk     <= 1'b0;
         driver_lat      <= 1'b0;
         drivers_sin     <= '0;
         driver_sout_mux <= '0;
      end else begin
         bit_done <= 1'b0;
         sample   <= 1'b0;
         // Free-running grayscale clock, parked low when disabled
         driver_gclk <= gclk_en_q ? ~driver_gclk : 1'b0;
         if (!step) begin
            driver_sclk <= 1'b0;
            if (load) begin
               step            <= 1'b1;
               // Lets the sequencer move on during the low half
               bit_done        <= 1'b1;
               driver_lat      <= cmd.lat;
               driver_sout_mux <= cmd.mux_sel;
               blank_q         <= cmd.blank;
               lod_q           <= (cmd.kind == kind_lod);
               gclk_en_q       <= cmd.gclk_en;
               case (cmd.kind)
                  kind_conf:  drivers_sin <= {n_drivers{conf_bit}};
                  kind_pixel: drivers_sin <= word;
                  default:    drivers_sin <= '0;
               endcase
            end
         end else begin
            // High half, no rise on blanking bits
            step        <= 1'b0;
            driver_sclk <= ~blank_q;
            sample      <= lod_q;
            sample_sel  <= driver_sout_mux;
         end
      end
   end

endmodule

// File: hw/driver/lod_collector.sv
// LED open detection collector

module lod_collector (
   input  logic                                clk_lse_quad,
   input  logic                                framebuffer_sync,
   // Strobe during the sclk high half of an lod bit
   input  logic                                sample,
   input  logic [led_drv_pkg::mux_w-1:0]       sample_sel,
   // Muxed serial output of the selected driver
   input  logic                                driver_sout,
   output logic [led_drv_pkg::n_drivers-1:0]   lod_mask,
   output logic                                lod_valid
);

   import led_drv_pkg::*;

   // Mask under construction
   logic [n_drivers-1:0] work_mask;
   // Last driver has just been captured
   logic                 last_q;

   always_ff @(posedge clk_lse_quad or posedge framebuffer_sync) begin
      if (framebuffer_sync) begin
         work_mask <= '0;
         last_q    <= 1'b0;
         lod_mask  <= '0;
         lod_valid <= 1'b0;
      end else begin
         last_q    <= 1'b0;
         lod_valid <= last_q;
         if (sample) begin
            work_mask[sample_sel] <= driver_sout;
            last_q <= (sample_sel == mux_w'(n_drivers - 1));
         end
         // Publish once the pass is complete
         if (last_q) begin
            lod_mask <= work_mask;
         end
      end
   end

endmodule

// File: hw/led_driver_top.sv
// LED driver chain controller

module led_driver_top #(
   parameter int slice_depth = 8,
   parameter int blank_bits  = 80
) (
   input  logic                                 clk_lse_quad,
   input  logic                                 framebuffer_sync,
   // Framebuffer source
   input  logic                                 pix_valid,
   input  led_drv_pkg::pixel_t                  pix_data,
   output logic                                 pix_credit,
   // Boot configuration word
   input  logic [led_drv_pkg::conf_bits-1:0]    serialized_conf,
   // Driver chain pins
   output logic                                 driver_sclk,
   output logic                                 driver_gclk,
   output logic                                 driver_lat,
   output led_drv_pkg::pixel_t                  drivers_sin,
   input  logic                                 driver_sout,
   output logic [led_drv_pkg::mux_w-1:0]        driver_sout_mux,
   // Open detection result
   output logic [led_drv_pkg::n_drivers-1:0]    lod_mask,
   output logic                                 lod_valid
);

   import led_drv_pkg::*;

   // Buffer to shifter
   logic     word_valid;
   pixel_t   word;
   logic     pop;
   // Sequencer to shifter
   bit_cmd_t cmd;
   logic     cmd_valid;
   logic     bit_done;
   // Shifter to collector
   logic             sample;
   logic [mux_w-1:0] sample_sel;

   slice_buffer #(
      .slice_depth (slice_depth)
   ) u_slice_buffer (
      .clk_lse_quad     (clk_lse_quad),
      .framebuffer_sync (framebuffer_sync),
      .push             (pix_valid),
      .push_data        (pix_data),
      .pop              (pop),
      .word_valid       (word_valid),
      .word             (word),
      .credit           (pix_credit)
   );

   driver_sequencer #(
      .blank_bits (blank_bits)
   ) u_driver_sequencer (
      .clk_lse_quad     (clk_lse_quad),
      .framebuffer_sync (framebuffer_sync),
      .bit_done         (bit_done),
      .cmd              (cmd),
      .cmd_valid        (cmd_valid)
   );

   driver_shifter u_driver_shifter (
      .clk_lse_quad     (clk_lse_quad),
      .framebuffer_sync (framebuffer_sync),
      .cmd              (cmd),
      .cmd_valid        (cmd_valid),
      .bit_done         (bit_done),
      .word_valid       (word_valid),
      .word             (word),
      .pop              (pop),
      .serialized_conf  (serialized_conf),
      .sample           (sample),
      .sample_sel       (sample_sel),
      .driver_sclk      (driver_sclk),
      .driver_gclk      (driver_gclk),
      .driver_lat       (driver_lat),
      .drivers_sin      (drivers_sin),
      .driver_sout_mux  (driver_sout_mux)
   );

   lod_collector u_lod_collector (
      .clk_lse_quad     (clk_lse_quad),
      .framebuffer_sync (framebuffer_sync),
      .sample           (sample),
      .sample_sel       (sample_sel),
      .driver_sout      (driver_sout),
      .lod_mask         (lod_mask),
      .lod_valid        (lod_valid)
   );

endmodule

// File: bench/led_driver_chk.sv
// Credit and pin rule checker

module led_driver_chk #(
   parameter int slice_depth = 8
) (
   input logic                clk_lse_quad,
   input logic                framebuffer_sync,
   input logic                pix_valid,
   input logic                pix_credit,
   input logic                driver_sclk,
   input logic                driver_lat,
   input led_drv_pkg::pixel_t drivers_sin
);

   timeunit 1ns;
   timeprecision 1ps;

   // Credits still held by the source
   int avail;

   always_ff @(posedge clk_lse_quad or posedge framebuffer_sync) begin
      if (framebuffer_sync) begin
         avail <= slice_depth;
      end else begin
         avail <= avail + int'(pix_credit) - int'(pix_valid);
      end
   end

   // Every push spends a credit the source holds
   push_needs_credit: assert property (@(posedge clk_lse_quad) disable iff (framebuffer_sync)
      pix_valid |-> avail > 0)
      else $error("Word pushed without a credit");

   // Returned credits never outgrow the FIFO
   credit_bound: assert property (@(posedge clk_lse_quad) disable iff (framebuffer_sync)
      avail <= slice_depth)
      else $error("Credit count above FIFO depth");

   // Shift clock is high for one cycle per bit
   sclk_single_cycle: assert property (@(posedge clk_lse_quad) disable iff (framebuffer_sync)
      driver_sclk |=> !driver_sclk)
      else $error("Shift clock high for more than one cycle");

   // Data and latch settle before the rise
   pins_stable_at_rise: assert property (@(posedge clk_lse_quad) disable iff (framebuffer_sync)
      $rose(driver_sclk) |-> $stable(drivers_sin) && $stable(driver_lat))
      else $error("Driver pins changed with the shift clock rise");

endmodule

// File: bench/led_driver_tb.sv
// LED driver chain testbench

module led_driver_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import led_drv_pkg::*;

   localparam int slice_depth = 8;
   localparam int blank_bits  = 80;
   localparam int clk_period  = 4;
   // Shift-clock rises per boot phase
   localparam int prep_rises  = fcwrten_bits;
   localparam int conf_rises  = conf_bits;
   localparam int boot_rises  = prep_rises + conf_rises + n_drivers;
   localparam int frame_bits  = n_segments * gs_bits;
   localparam int n_frames    = 3;
   localparam int total_rises = boot_rises + n_frames * frame_bits;
   // Boot bits include the stall bit, worst stall stretches a bit fourfold
   localparam int stall_factor = 4;
   localparam int limit_cycles =
      (boot_rises + 1 + n_frames * (blank_bits + frame_bits)) * 2 * stall_factor + 20;

   logic                 clk_lse_quad;
   logic                 framebuffer_sync;
   logic                 pix_valid;
   pixel_t               pix_data;
   logic                 pix_credit;
   logic [conf_bits-1:0] serialized_conf;
   logic                 driver_sclk;
   logic                 driver_gclk;
   logic                 driver_lat;
   pixel_t               drivers_sin;
   logic                 driver_sout;
   logic [mux_w-1:0]     driver_sout_mux;
   logic [n_drivers-1:0] lod_mask;
   logic                 lod_valid;

   // Reference model state
   integer               seed = 32'ha92060dd;
   pixel_t               sent_q [$];
   int                   credits = slice_depth;
   logic [n_drivers-1:0] open_mask;
   int                   rise_cnt = 0;
   int                   gap_cycles = 0;
   int                   gclk_toggles = 0;
   logic                 gclk_prev = 1'b0;
   int                   lod_count = 0;

   led_driver_top #(
      .slice_depth (slice_depth),
      .blank_bits  (blank_bits)
   ) DUT (
      .clk_lse_quad     (clk_lse_quad),
      .framebuffer_sync (framebuffer_sync),
      .pix_valid        (pix_valid),
      .pix_data         (pix_data),
      .pix_credit       (pix_credit),
      .serialized_conf  (serialized_conf),
      .driver_sclk      (driver_sclk),
      .driver_gclk      (driver_gclk),
      .driver_lat       (driver_lat),
      .drivers_sin      (drivers_sin),
      .driver_sout      (driver_sout),
      .driver_sout_mux  (driver_sout_mux),
      .lod_mask         (lod_mask),
      .lod_valid        (lod_valid)
   );

   bind led_driver_top led_driver_chk #(.slice_depth(slice_depth)) u_chk (
      .clk_lse_quad     (clk_lse_quad),
      .framebuffer_sync (framebuffer_sync),
      .pix_valid        (pix_valid),
      .pix_credit       (pix_credit),
      .driver_sclk      (driver_sclk),
      .driver_lat       (driver_lat),
      .drivers_sin      (drivers_sin)
   );

   always #(clk_period / 2) clk_lse_quad = ~clk_lse_quad;

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic compare_pixel(input string test, input pixel_t expected, input pixel_t actual);
      if (actual !== expected) begin
         abort_run($sformatf("Error %s: expected %h, actual %h", test, expected, actual));
      end
   endtask

   task automatic compare_conf_bit(input string test, input logic expected, input logic actual);
      if (actual !== expected) begin
         abort_run($sformatf("Error %s: expected %b, actual %b", test, expected, actual));
      end
   endtask

   task automatic compare_lod(input string test, input logic [n_drivers-1:0] expected,
                              input logic [n_drivers-1:0] actual);
      if (actual !== expected) begin
         abort_run($sformatf("Error %s: expected %h, actual %h", test, expected, actual));
      end
   endtask

   task automatic compare_lat(input string test, input logic expected, input logic actual);
      if (actual !== expected) begin
         abort_run($sformatf("Error %s: expected %b, actual %b", test, expected, actual));
      end
   endtask

   // Expected pins at one shift-clock rise, by position in the schedule
   task automatic check_rise();
      int     idx;
      int     k;
      int     seg;
      int     b;
      pixel_t expected_word;
      if (rise_cnt < prep_rises) begin
         compare_lat("prepare latch", 1'b1, driver_lat);
         compare_pixel("prepare data", '0, drivers_sin);
      end else if (rise_cnt < prep_rises + conf_rises) begin
         idx = rise_cnt - prep_rises;
         // Write latch over the last five bits of the word
         compare_lat("config latch", idx >= conf_bits - wrtfc_bits, driver_lat);
         for (int j = 0; j < n_drivers; j++) begin
            compare_conf_bit("config data", serialized_conf[conf_bits - 1 - idx], drivers_sin[j]);
         end
      end else if (rise_cnt < boot_rises) begin
         compare_lat("lod latch", 1'b0, driver_lat);
         compare_pixel("lod data", '0, drivers_sin);
      end else begin
         k   = (rise_cnt - boot_rises) % frame_bits;
         seg = k / gs_bits;
         b   = k % gs_bits;
         // First pixel of a frame follows the blanking gap
         if (k == 0 && (gap_cycles < 2 * blank_bits || gclk_toggles < 2 * blank_bits)) begin
            abort_run($sformatf("Blanking too short before frame: %0d quiet cycles, %0d gclk edges",
                                gap_cycles, gclk_toggles));
         end
         if (sent_q.size() == 0) begin
            abort_run("A pixel word was shifted out that the source never sent");
         end
         expected_word = sent_q.pop_front();
         compare_pixel("stream data", expected_word, drivers_sin);
         // Last segment holds latch for three bits, the others for one
         if (seg == n_segments - 1) begin
            compare_lat("stream latch", b >= gs_bits - 3, driver_lat);
         end else begin
            compare_lat("stream latch", b == gs_bits - 1, driver_lat);
         end
      end
   endtask

   // Framebuffer source with random gaps, plus the open LED model
   always @(posedge clk_lse_quad) begin : source
      pixel_t word_v;
      driver_sout <= open_mask[driver_sout_mux];
      if (framebuffer_sync) begin
         pix_valid <= 1'b0;
      end else begin
         if (pix_credit) begin
            credits = credits + 1;
         end
         if (credits > slice_depth) begin
            abort_run("More credits came back than words were sent");
         end
         if (credits > 0 && ($random(seed) & 3) != 0) begin
            word_v = pixel_t'($random(seed));
            pix_valid <= 1'b1;
            pix_data  <= word_v;
            sent_q.push_back(word_v);
            credits = credits - 1;
         end else begin
            pix_valid <= 1'b0;
         end
      end
   end

   // Pins are stable at the falling edge
   always @(negedge clk_lse_quad) begin : monitor
      if (!framebuffer_sync) begin
         if (lod_valid) begin
            lod_count = lod_count + 1;
            compare_lod("lod mask", open_mask, lod_mask);
         end
         if (rise_cnt < boot_rises && driver_gclk) begin
            abort_run("Grayscale clock toggled before streaming began");
         end
         if (driver_gclk != gclk_prev) begin
            gclk_toggles = gclk_toggles + 1;
         end
         gclk_prev = driver_gclk;
         // Shift clock is high for a single cycle per rise
         if (driver_sclk) begin
            check_rise();
            rise_cnt     = rise_cnt + 1;
            gap_cycles   = 0;
            gclk_toggles = 0;
         end else begin
            gap_cycles = gap_cycles + 1;
         end
      end
   end

   initial begin : main
      logic [conf_bits-1:0] conf_v;
      clk_lse_quad     = 1'b0;
      framebuffer_sync = 1'b1;
      pix_valid        = 1'b0;
      pix_data         = '0;
      serialized_conf  = '0;
      driver_sout      = 1'b0;
      conf_v    = conf_bits'({$random(seed), $random(seed)});
      open_mask = n_drivers'($random(seed));
      @(posedge clk_lse_quad);
      serialized_conf <= conf_v;
      repeat (9) @(posedge clk_lse_quad);
      framebuffer_sync <= 1'b0;
      wait (rise_cnt == total_rises);
      repeat (2) @(posedge clk_lse_quad);
      if (lod_count != 1) begin
         abort_run($sformatf("Open detection result came %0d times instead of once", lod_count));
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

   // Boot plus three frames at the worst stall rate
   initial begin : watchdog
      #(limit_cycles * clk_period);
      abort_run("Timeout, the three frames did not finish in time");
   end

endmodule

// File: verilog.f
common/led_drv_pkg.sv
hw/slice_buffer.sv
hw/driver/driver_sequencer.sv
hw/driver/driver_shifter.sv
hw/driver/lod_collector.sv
hw/led_driver_top.sv
bench/led_driver_chk.sv
bench/led_driver_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module led_driver_tb -f verilog.f -o led_driver_sim

out=$(./obj_dir/led_driver_sim 2>&1 || true)
echo "$out"
echo "$out" | grep -qx "All tests passed"
